/* verilog/rtg_video_pkg.sv */
// Shared widths, colour and sync structs, vblank FSM states and OSD overlay levels
package rtg_video_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int COLOUR_W    = 8;   // One colour channel
  localparam int PIX_WORD_W  = 16;  // Fetched RTG word
  localparam int CLUT_IDX_W  = 8;   // 256-entry palette
  localparam int PIX_WIDTH_W = 4;   // Up to 16 clocks per fetch
  localparam int LINE_CNT_W  = 7;   // Up to 127 extra blank lines

  typedef logic [COLOUR_W-1:0]    colour_t;
  typedef logic [PIX_WORD_W-1:0]  pix_word_t;
  typedef logic [CLUT_IDX_W-1:0]  clut_idx_t;
  typedef logic [PIX_WIDTH_W-1:0] pix_width_t;  // Fetch period minus one
  typedef logic [LINE_CNT_W-1:0]  line_cnt_t;

  ////////////////////
  // Bundles
  ////////////////////

  typedef struct packed {
    colour_t red;
    colour_t green;
    colour_t blue;
  } rgb_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic csync;
  } sync_t;

  // Picture blank stretch past chipset vblank
  typedef enum logic {
    VB_ACTIVE = 1'b0,  // RTG picture shown
    VB_HOLD   = 1'b1   // Still counting lines
  } vb_state_e;

  ////////////////////
  // OSD levels
  ////////////////////

  localparam logic [1:0] OSD_ON_LEVEL  = 2'b11;          // Lit pixel, all channels
  localparam logic [5:0] OSD_OFF_LEVEL = {2'b00,          // Red
                                          2'b00,          // Green
                                          2'b10};         // Blue, dimmed backdrop

endpackage

/* verilog/rtg_vblank_fsm.sv */
// Vertical blank extension FSM for the RTG picture, counting scan lines after chipset vblank
`timescale 1ns/10ps

module rtg_vblank_fsm (
  input  logic                  clk_114,
  input  logic                  rst_n,
  input  logic                  chip_vblank,  // Chipset vertical blank
  input  logic                  hsync,        // Line pulse from chipset sync
  input  rtg_video_pkg::line_cnt_t vb_end,    // Extra lines to hold blank
  output logic                  rtg_vblank
);

  import rtg_video_pkg::*;

  vb_state_e state;
  line_cnt_t line_cnt;  // Lines seen since vblank fell
  logic      hsync_q;   // Previous hsync level
  logic      hsync_rise;

  assign hsync_rise = hsync & ~hsync_q;

  ////////////////////
  // Edge detect
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      hsync_q <= 1'b0;
    end else begin
      hsync_q <= hsync;
    end
  end

  ////////////////////
  // State and count
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      state    <= VB_HOLD;             // Blank until first frame settles
      line_cnt <= '0;
    end else if (chip_vblank) begin
      state    <= VB_HOLD;             // Restart stretch every frame
      line_cnt <= '0;
    end else if (state == VB_HOLD) begin
      if (line_cnt == vb_end) begin
        state <= VB_ACTIVE;            // Enough lines, open picture
      end else if (hsync_rise) begin
        line_cnt <= line_cnt + 1'b1;   // One more line gone
      end
    end
  end

  // Picture blanked for the whole hold
  assign rtg_vblank = (state == VB_HOLD);

endmodule

/* verilog/rtg_fetch_timer.sv */
// Pixel fetch timer making the fetch strobe and the CLUT half-period flag
`timescale 1ns/10ps

module rtg_fetch_timer (
  input  logic                      clk_114,
  input  logic                      rst_n,
  input  logic                      rtg_ena,    // RTG screen on
  input  logic                      rtg_blank,  // Vertical or horizontal blank
  input  rtg_video_pkg::pix_width_t pix_width,  // Clocks per fetch minus one
  output logic                      fetch_strobe,
  output logic                      clut_half
);

  import rtg_video_pkg::*;

  pix_width_t pix_cnt;   // Clocks into current fetch period
  pix_width_t half_cnt;  // Midpoint of the period
  logic       cnt_clr;

  assign half_cnt = {1'b0, pix_width[PIX_WIDTH_W-1:1]};

  // Ask for next word at end of period, never in blank
  assign fetch_strobe = rtg_ena && !rtg_blank && (pix_cnt == pix_width);

  // Restart the period on strobe, blank or when RTG is off
  assign cnt_clr = rtg_blank || fetch_strobe || !rtg_ena;

  ////////////////////
  // Period counter
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      pix_cnt   <= '0;
      clut_half <= 1'b0;
    end else if (cnt_clr) begin
      pix_cnt   <= '0;
      clut_half <= 1'b0;               // First byte again
    end else begin
      pix_cnt <= pix_cnt + 1'b1;
      if (pix_cnt == half_cnt) begin
        clut_half <= 1'b1;             // Second half, second byte
      end
    end
  end

endmodule

/* verilog/rtg_pixel_unpack.sv */
// Fetched word register, CLUT index select and hi-colour expansion to 8 bits per channel
`timescale 1ns/10ps

module rtg_pixel_unpack (
  input  logic                     clk_114,
  input  logic                     rst_n,
  input  logic                     fetch_strobe,  // Word valid on pix_word
  input  logic                     clut_half,     // Second half of fetch period
  input  rtg_video_pkg::pix_word_t pix_word,
  output rtg_video_pkg::clut_idx_t clut_idx,      // To external CLUT
  output rtg_video_pkg::rgb_t      hicolour_rgb
);

  import rtg_video_pkg::*;

  pix_word_t word_q;       // Last fetched word
  logic      clut_half_q;  // Byte select, one clock behind timer

  // 5-bit field to 8 bits, top bits repeated below
  function automatic colour_t expand5(input logic [4:0] field);
    colour_t res;
    res = {field, field[4:2]};
    return res;
  endfunction

  ////////////////////
  // Word hold
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (fetch_strobe) begin
      word_q <= pix_word;              // Held until next strobe
    end
  end

  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      clut_half_q <= 1'b0;
    end else begin
      clut_half_q <= clut_half;
    end
  end

  ////////////////////
  // Unpack
  ////////////////////

  // High byte first, low byte in second half
  assign clut_idx = clut_half_q ? word_q[7:0] : word_q[15:8];

  assign hicolour_rgb.red   = expand5(word_q[14:10]);  // Bit 15 unused
  assign hicolour_rgb.green = expand5(word_q[9:5]);
  assign hicolour_rgb.blue  = expand5(word_q[4:0]);

endmodule

/* verilog/rtg_video_mixer.sv */
// RTG or native source select, OSD overlay and registered colour and sync outputs
`timescale 1ns/10ps

module rtg_video_mixer (
  input  logic                 clk_114,
  input  logic                 rst_n,
  input  logic                 rtg_ena,       // RTG screen on
  input  logic                 rtg_clut,      // CLUT mode, else hi-colour
  input  logic                 rtg_blank,
  input  rtg_video_pkg::rgb_t  hicolour_rgb,
  input  rtg_video_pkg::rgb_t  clut_rgb,      // From external CLUT
  input  rtg_video_pkg::rgb_t  native_rgb,    // Chipset video
  input  rtg_video_pkg::sync_t sync_in,
  input  logic                 osd_window,    // OSD area on screen
  input  logic                 osd_pixel,     // OSD foreground
  output rtg_video_pkg::rgb_t  video_rgb,
  output rtg_video_pkg::sync_t video_sync
);

  import rtg_video_pkg::*;

  logic  rtg_blank_d;
  logic  rtg_blank_d2;  // Lines up with unpacked pixel
  logic  rtg_sel;
  rgb_t  rtg_rgb;
  rgb_t  colour_q;      // Stage one colour
  sync_t sync_q;        // Stage one sync

  // OSD level on top, picture dimmed below
  function automatic colour_t overlay(input colour_t c, input logic [1:0] lvl);
    colour_t res;
    res = {lvl, c[7:2]};
    return res;
  endfunction

  assign rtg_sel = rtg_ena && !rtg_blank_d2;
  assign rtg_rgb = rtg_clut ? clut_rgb : hicolour_rgb;

  ////////////////////
  // Stage one
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      rtg_blank_d  <= 1'b1;
      rtg_blank_d2 <= 1'b1;
      colour_q     <= '0;
      sync_q       <= '0;
    end else begin
      rtg_blank_d  <= rtg_blank;
      rtg_blank_d2 <= rtg_blank_d;
      colour_q     <= rtg_sel ? rtg_rgb : native_rgb;  // Native in RTG blank
      sync_q       <= sync_in;
    end
  end

  ////////////////////
  // Stage two
  ////////////////////

  always_ff @(posedge clk_114) begin
    if (!rst_n) begin
      video_rgb  <= '0;
      video_sync <= '0;
    end else begin
      video_sync <= sync_q;
      if (osd_window) begin
        video_rgb.red   <= overlay(colour_q.red,   osd_pixel ? OSD_ON_LEVEL : OSD_OFF_LEVEL[5:4]);
        video_rgb.green <= overlay(colour_q.green, osd_pixel ? OSD_ON_LEVEL : OSD_OFF_LEVEL[3:2]);
        video_rgb.blue  <= overlay(colour_q.blue,  osd_pixel ? OSD_ON_LEVEL : OSD_OFF_LEVEL[1:0]);
      end else begin
        video_rgb <= colour_q;         // Plain picture
      end
    end
  end

endmodule

/* verilog/rtg_video_top.sv */
// Top level of the RTG video path joining vblank FSM, fetch timer, unpack and mixer
`timescale 1ns/10ps

module rtg_video_top (
  input  logic                      clk_114,
  input  logic                      rst_n,
  input  logic                      rtg_ena,      // RTG screen on
  input  logic                      rtg_clut,     // CLUT or hi-colour
  input  rtg_video_pkg::pix_width_t pix_width,
  input  rtg_video_pkg::line_cnt_t  vb_end,
  input  logic                      chip_hblank,
  input  logic                      chip_vblank,
  input  rtg_video_pkg::sync_t      sync_in,
  input  rtg_video_pkg::rgb_t       native_rgb,
  input  logic                      osd_window,
  input  logic                      osd_pixel,
  input  rtg_video_pkg::pix_word_t  pix_word,     // From video stream
  input  rtg_video_pkg::rgb_t       clut_rgb,     // From external CLUT
  output logic                      fetch_strobe, // Next word request
  output rtg_video_pkg::clut_idx_t  clut_idx,
  output rtg_video_pkg::rgb_t       video_rgb,
  output rtg_video_pkg::sync_t      video_sync
);

  import rtg_video_pkg::*;

  logic rtg_vblank;
  logic rtg_blank;     // Any blank for RTG picture
  logic clut_half;
  rgb_t hicolour_rgb;

  assign rtg_blank = rtg_vblank | chip_hblank;

  rtg_vblank_fsm rtg_vblank_fsm_inst (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .chip_vblank(chip_vblank),
    .hsync      (sync_in.hsync),
    .vb_end     (vb_end),
    .rtg_vblank (rtg_vblank)
  );

  rtg_fetch_timer rtg_fetch_timer_inst (
    .clk_114     (clk_114),
    .rst_n       (rst_n),
    .rtg_ena     (rtg_ena),
    .rtg_blank   (rtg_blank),
    .pix_width   (pix_width),
    .fetch_strobe(fetch_strobe),
    .clut_half   (clut_half)
  );

  rtg_pixel_unpack rtg_pixel_unpack_inst (
    .clk_114     (clk_114),
    .rst_n       (rst_n),
    .fetch_strobe(fetch_strobe),
    .clut_half   (clut_half),
    .pix_word    (pix_word),
    .clut_idx    (clut_idx),
    .hicolour_rgb(hicolour_rgb)
  );

  rtg_video_mixer rtg_video_mixer_inst (
    .clk_114     (clk_114),
    .rst_n       (rst_n),
    .rtg_ena     (rtg_ena),
    .rtg_clut    (rtg_clut),
    .rtg_blank   (rtg_blank),
    .hicolour_rgb(hicolour_rgb),
    .clut_rgb    (clut_rgb),
    .native_rgb  (native_rgb),
    .sync_in     (sync_in),
    .osd_window  (osd_window),
    .osd_pixel   (osd_pixel),
    .video_rgb   (video_rgb),
    .video_sync  (video_sync)
  );

endmodule

/* tests/rtg_video_checker.sv */
// Bound assertions on fetch strobe timing and on output reset state
`timescale 1ns/10ps

module rtg_video_checker (
  input logic                      clk_114,
  input logic                      rst_n,
  input logic                      chip_hblank,
  input rtg_video_pkg::pix_width_t pix_width,
  input logic                      fetch_strobe,
  input rtg_video_pkg::rgb_t       video_rgb,
  input rtg_video_pkg::sync_t      video_sync
);

  import rtg_video_pkg::*;

  // No strobe in the first clock after line blank
  a_blank_restart: assert property (@(posedge clk_114) disable iff (!rst_n)
    $fell(chip_hblank) |-> (!fetch_strobe || pix_width == '0))
    else $error("fetch strobe in first clock after line blank");

  // Counter restarts, so a strobe is a single pulse unless period is one clock
  a_strobe_pulse: assert property (@(posedge clk_114) disable iff (!rst_n)
    (fetch_strobe && pix_width != '0) |=> (!fetch_strobe || pix_width == '0))
    else $error("fetch strobe longer than one clock");

  // Outputs forced to zero by reset
  a_reset_out: assert property (@(posedge clk_114)
    !rst_n |=> (video_rgb == '0 && video_sync == '0))
    else $error("video outputs not cleared by reset");

endmodule

/* tests/rtg_video_tb.sv */
// Testbench for the RTG video path with reference model, compare process and timeout
`timescale 1ns/10ps

module rtg_video_tb;

  import rtg_video_pkg::*;

  localparam int CYCLE_LIMIT = 3000;  // Sum of phase lengths with margin

  logic        clk_114;
  logic        rst_n;
  logic        rtg_ena;
  logic        rtg_clut;
  logic        chip_hblank;
  logic        chip_vblank;
  logic        osd_window;
  logic        osd_pixel;
  logic        fetch_strobe;
  logic        mix_chk;
  logic [3:0]  pix_width;
  logic [6:0]  vb_end;
  logic [15:0] pix_word;
  logic [7:0]  clut_idx;
  rgb_t        native_rgb;
  rgb_t        clut_rgb;
  rgb_t        video_rgb;
  sync_t       sync_in;
  sync_t       video_sync;
  int          cycle_cnt = 0;

  // Testbench CLUT, combinational lookup
  assign clut_rgb = {clut_idx, ~clut_idx, clut_idx ^ 8'h5a};

  rtg_video_top rtg_video_top_inst (.*);

  bind rtg_video_top rtg_video_checker rtg_video_checker_inst (
    .clk_114(clk_114), .rst_n(rst_n), .chip_hblank(chip_hblank),
    .pix_width(pix_width), .fetch_strobe(fetch_strobe), .video_rgb(video_rgb),
    .video_sync(video_sync)
  );

  initial begin
    clk_114 = 1'b0;
    forever #50 clk_114 = ~clk_114;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Mixer output for native colour with OSD window and pixel
  function automatic rgb_t expected_rgb(input rgb_t c, input logic win, input logic pix);
    rgb_t res;
    res = c;
    if (win) begin
      res.red   = {pix ? 2'b11 : 2'b00, c.red[7:2]};
      res.green = {pix ? 2'b11 : 2'b00, c.green[7:2]};
      res.blue  = {pix ? 2'b11 : 2'b10, c.blue[7:2]};  // Dimmed blue backdrop
    end
    return res;
  endfunction

  // 15-bit hi-colour word to 8 bits per channel
  function automatic rgb_t expand_word(input logic [15:0] w);
    rgb_t res;
    res.red   = (8'(w[14:10]) << 3) | 8'(w[14:12]);
    res.green = (8'(w[9:5]) << 3) | 8'(w[9:7]);
    res.blue  = (8'(w[4:0]) << 3) | 8'(w[4:2]);
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  ////////////////////
  // Compare process
  ////////////////////

  rgb_t  prev_rgb;
  sync_t prev_sync;
  logic  prev_chk = 1'b0;

  always @(negedge clk_114) begin
    if (mix_chk && prev_chk) begin
      check_value("video_rgb", video_rgb, expected_rgb(prev_rgb, osd_window, osd_pixel));
      check_value("video_sync", video_sync, prev_sync);
    end
    prev_rgb  = native_rgb;  // Stage one input of this cycle
    prev_sync = sync_in;
    prev_chk  = mix_chk;
  end

  always @(posedge clk_114) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within the cycle limit");
      $display("Test failures found");
      $fatal(1);
    end
  end

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic drive_native(input int n, input logic win);
    repeat (n) begin
      @(negedge clk_114);
      native_rgb <= $urandom;
      sync_in    <= $urandom;
      osd_window <= win;
      osd_pixel  <= $urandom;
      mix_chk    <= 1'b1;
    end
    @(negedge clk_114);
    mix_chk <= 1'b0;
  endtask

  // Cycles until next strobe, fails in plain words past the limit
  task automatic wait_strobe(input int limit, output int n);
    n = 0;
    do begin
      @(negedge clk_114);
      n++;
      if (n > limit) begin
        $display("No fetch strobe seen within %0d cycles", limit);
        $display("Test failures found");
        $fatal(1);
      end
    end while (!fetch_strobe);
  endtask

  task automatic expect_no_strobe(input int n);
    repeat (n) begin
      @(negedge clk_114);
      check_value("fetch_strobe", fetch_strobe, 0);
    end
  endtask

  task automatic measure_gaps(input logic [3:0] w);
    int n;
    @(negedge clk_114);
    pix_width   <= w;
    chip_hblank <= 1'b1;
    expect_no_strobe(3);
    chip_hblank <= 1'b0;                // Released mid-cycle
    wait_strobe(20, n);
    check_value("first strobe delay", n, w);
    repeat (3) begin
      wait_strobe(20, n);
      check_value("strobe gap", n, w + 1);
    end
  endtask

  initial begin
    int      n;
    int      seed;
    logic [15:0] w;
    logic [6:0]  lines;
    seed = $urandom(32'hc3c9);
    rst_n = 1'b0;
    rtg_ena = 1'b0;
    rtg_clut = 1'b0;
    chip_hblank = 1'b0;
    chip_vblank = 1'b0;
    osd_window = 1'b0;
    osd_pixel = 1'b0;
    mix_chk = 1'b0;
    pix_width = 4'd7;
    vb_end = '0;                        // FSM opens right after reset
    pix_word = '0;
    native_rgb = '0;
    sync_in = '0;
    repeat (5) @(negedge clk_114);
    rst_n <= 1'b1;
    drive_native(150, 1'b0);            // Native pass-through
    drive_native(150, 1'b1);            // OSD overlay
    sync_in <= '0;
    osd_window <= 1'b0;
    expect_no_strobe(5);                // RTG off
    rtg_ena <= 1'b1;
    repeat (4) measure_gaps(4'($urandom_range(15, 1)));
    // Vblank stretch by a random line count
    repeat (3) begin
      lines = 7'($urandom_range(6, 1));
      @(negedge clk_114);
      vb_end      <= lines;
      chip_vblank <= 1'b1;
      expect_no_strobe(4);
      chip_vblank <= 1'b0;
      repeat (lines) begin
        expect_no_strobe(1);
        sync_in.hsync <= 1'b1;
        expect_no_strobe(1);
        sync_in.hsync <= 1'b0;
      end
      expect_no_strobe(1);
      wait_strobe(40, n);
      check_value("strobe after vblank", n, pix_width);
    end
    // Hi-colour pixels through the mixer
    pix_width <= 4'($urandom_range(15, 7));
    repeat (8) begin
      do begin
        @(negedge clk_114);
        w = 16'($urandom);
        pix_word <= w;                  // Captured on this strobe
      end while (!fetch_strobe);
      repeat (4) @(negedge clk_114);
      check_value("video_rgb", video_rgb, expand_word(w));
    end
    // CLUT mode, high byte then low byte
    rtg_clut <= 1'b1;
    repeat (8) begin
      do begin
        @(negedge clk_114);
        w = 16'($urandom);
        pix_word <= w;
      end while (!fetch_strobe);
      @(negedge clk_114);
      @(negedge clk_114);
      check_value("clut_idx", clut_idx, w[15:8]);
      @(negedge clk_114);
      @(negedge clk_114);
      check_value("video_rgb", video_rgb, {w[15:8], ~w[15:8], w[15:8] ^ 8'h5a});
      repeat (pix_width - 4) @(negedge clk_114);
      check_value("clut_idx", clut_idx, w[7:0]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

/* rtg_video_top.f */
verilog/rtg_video_pkg.sv
verilog/rtg_vblank_fsm.sv
verilog/rtg_fetch_timer.sv
verilog/rtg_pixel_unpack.sv
verilog/rtg_video_mixer.sv
verilog/rtg_video_top.sv
tests/rtg_video_checker.sv
tests/rtg_video_tb.sv

/* Makefile */
SRCS := $(wildcard verilog/*.sv) $(wildcard tests/*.sv) rtg_video_top.f

.PHONY: all run clean

all: obj_dir/Vrtg_video_tb

obj_dir/Vrtg_video_tb: $(SRCS)
	verilator --binary --timing --assert --top-module rtg_video_tb -f rtg_video_top.f

run: obj_dir/Vrtg_video_tb
	./obj_dir/Vrtg_video_tb | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
